/* Bender.yml */
package:
  name: lsu_stage

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/lsu_fsm.sv
      - hw/lsu_store_align.sv
      - hw/lsu_load_extract.sv
      - hw/lsu_writeback.sv
      - hw/lsu_top.sv

  - target: test
    files:
      - test/tb_axi_mem.sv
      - test/tb_lsu_top.sv

/* hw/lsu_fsm.sv */
`timescale 1ns/1ps

module lsu_fsm (
  input  logic             clock,
  input  logic             reset,

  // Upstream handshake from execute
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  lsu_pkg::lsu_req_t req_i,

  // Downstream handshake to writeback
  output logic             res_valid_o,
  input  logic             res_ready_i,

  // Captured request for the datapath blocks
  output lsu_pkg::lsu_req_t req_q_o,

  // AW channel
  output logic             aw_valid_o,
  input  logic             aw_ready_i,

  // W channel
  output logic             w_valid_o,
  input  logic             w_ready_i,

  // B channel
  input  logic             b_valid_i,
  output logic             b_ready_o,

  // AR channel
  output logic             ar_valid_o,
  input  logic             ar_ready_i,

  // R channel
  input  logic             r_valid_i,
  input  logic             r_last_i,
  output logic             r_ready_o,

  // Capture strobes for the result register
  output logic             acc_alu_o,
  output logic             r_done_o,
  output logic             b_done_o
);

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    WAIT_AR   = 3'd1,
    WAIT_R    = 3'd2,
    WAIT_AW   = 3'd3,
    WAIT_W    = 3'd4,
    WAIT_B    = 3'd5,
    WAIT_POST = 3'd6
  } state_e;

  state_e            cur_state;
  state_e            next_state;
  logic              accept;
  lsu_pkg::lsu_req_t req_q;

  // --------------------------------------------------
  // Handshake and strobe decode
  // --------------------------------------------------
  assign req_ready_o = (cur_state == IDLE);
  assign res_valid_o = (cur_state == WAIT_POST);

  assign aw_valid_o  = (cur_state == WAIT_AW);
  assign w_valid_o   = (cur_state == WAIT_W);
  assign b_ready_o   = (cur_state == WAIT_B);
  assign ar_valid_o  = (cur_state == WAIT_AR);
  assign r_ready_o   = (cur_state == WAIT_R);

  assign accept    = req_valid_i && req_ready_o;
  assign acc_alu_o = accept && (req_i.kind == lsu_pkg::KIND_ALU);
  assign r_done_o  = r_valid_i && r_ready_o && r_last_i;
  assign b_done_o  = b_valid_i && b_ready_o;

  assign req_q_o = req_q;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      cur_state <= IDLE;
    end else begin
      cur_state <= next_state;
    end
  end

  // Request stays put until the stage is idle again
  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    next_state = cur_state;
    case (cur_state)
      IDLE: begin
        if (req_valid_i) begin
          case (req_i.kind)
            lsu_pkg::KIND_LOAD:  next_state = WAIT_AR;
            lsu_pkg::KIND_STORE: next_state = WAIT_AW;
            default:             next_state = WAIT_POST;
          endcase
        end
      end
      // Load path
      WAIT_AR: begin
        if (ar_ready_i) begin
          next_state = WAIT_R;
        end
      end
      WAIT_R: begin
        if (r_valid_i && r_last_i) begin
          next_state = WAIT_POST;
        end
      end
      // Store path, address first then data
      WAIT_AW: begin
        if (aw_ready_i) begin
          next_state = WAIT_W;
        end
      end
      WAIT_W: begin
        if (w_ready_i) begin
          next_state = WAIT_B;
        end
      end
      WAIT_B: begin
        if (b_valid_i) begin
          next_state = WAIT_POST;
        end
      end
      // Hold the result until writeback takes it
      WAIT_POST: begin
        if (res_ready_i) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

endmodule

/* hw/lsu_load_extract.sv */
`timescale 1ns/1ps

module lsu_load_extract #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  lsu_pkg::lsu_req_t         req_q_i,
  output lsu_pkg::axi_ar_t          ar_o,
  input  logic [lsu_pkg::XLEN-1:0]  r_data_i,
  output logic [lsu_pkg::XLEN-1:0]  load_data_o
);

  logic [4:0]               shamt;
  logic [lsu_pkg::XLEN-1:0] shifted;

  // --------------------------------------------------
  // Read address channel
  // --------------------------------------------------
  assign ar_o.id   = AXI_ID;
  assign ar_o.addr = req_q_i.addr;
  assign ar_o.size = lsu_pkg::funct3_to_size(req_q_i.funct3);

  // --------------------------------------------------
  // Lane extraction
  // --------------------------------------------------

  // Byte offset in bits
  assign shamt   = {req_q_i.addr[1:0], 3'b000};
  assign shifted = r_data_i >> shamt;

  always_comb begin
    case (req_q_i.funct3)
      lsu_pkg::LB: begin
        load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::LH: begin
        load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::LBU: begin
        load_data_o = {24'd0, shifted[7:0]};
      end
      lsu_pkg::LHU: begin
        load_data_o = {16'd0, shifted[15:0]};
      end
      lsu_pkg::LW: begin
        load_data_o = shifted;
      end
      // Unused codes, treat as word
      default: begin
        load_data_o = shifted;
      end
    endcase
  end

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

  // Data and address width
  parameter int XLEN = 32;

  // Instruction kinds handed over by execute
  typedef enum logic [1:0] {
    KIND_ALU   = 2'd0,
    KIND_LOAD  = 2'd1,
    KIND_STORE = 2'd2
  } inst_kind_e;

  // Load funct3 codes
  localparam logic [2:0] LB  = 3'b000;
  localparam logic [2:0] LH  = 3'b001;
  localparam logic [2:0] LW  = 3'b010;
  localparam logic [2:0] LBU = 3'b100;
  localparam logic [2:0] LHU = 3'b101;

  // Store funct3 codes
  localparam logic [2:0] SB  = 3'b000;
  localparam logic [2:0] SH  = 3'b001;
  localparam logic [2:0] SW  = 3'b010;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // --------------------------------------------------
  // Stage payloads
  // --------------------------------------------------
  typedef struct packed {
    inst_kind_e      kind;
    logic [2:0]      funct3;
    logic [XLEN-1:0] addr;   // result value for ALU kind
    logic [XLEN-1:0] wdata;
    logic [4:0]      rd;
  } lsu_req_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            rd_we;
    logic            fault;
  } wb_res_t;

  // --------------------------------------------------
  // AXI4 channel payloads
  // --------------------------------------------------
  typedef struct packed {
    logic [3:0]      id;
    logic [XLEN-1:0] addr;
    logic [2:0]      size;
  } axi_aw_t;

  typedef struct packed {
    logic [3:0]      id;
    logic [XLEN-1:0] addr;
    logic [2:0]      size;
  } axi_ar_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [3:0]      strb;
    logic            last;
  } axi_w_t;

  typedef struct packed {
    logic [3:0] id;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [3:0]      id;
    logic [XLEN-1:0] data;
    logic [1:0]      resp;
    logic            last;
  } axi_r_t;

  // Byte, half and word map straight onto AXI size 0, 1, 2
  function automatic logic [2:0] funct3_to_size(input logic [2:0] funct3);
    return {1'b0, funct3[1:0]};
  endfunction

endpackage

/* hw/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  lsu_pkg::lsu_req_t req_q_i,
  output lsu_pkg::axi_aw_t  aw_o,
  output lsu_pkg::axi_w_t   w_o
);

  logic [lsu_pkg::XLEN-1:0] lane_data;
  logic [3:0]               strb_base;
  logic [1:0]               byte_off;

  assign byte_off = req_q_i.addr[1:0];

  // --------------------------------------------------
  // Lane replication and strobe width
  // --------------------------------------------------
  always_comb begin
    case (req_q_i.funct3)
      lsu_pkg::SB: begin
        lane_data = {4{req_q_i.wdata[7:0]}};
        strb_base = 4'b0001;
      end
      lsu_pkg::SH: begin
        lane_data = {2{req_q_i.wdata[15:0]}};
        strb_base = 4'b0011;
      end
      lsu_pkg::SW: begin
        lane_data = req_q_i.wdata;
        strb_base = 4'b1111;
      end
      default: begin
        lane_data = req_q_i.wdata;
        strb_base = 4'b1111;
      end
    endcase
  end

  // Address channel
  assign aw_o.id   = AXI_ID;
  assign aw_o.addr = req_q_i.addr;
  assign aw_o.size = lsu_pkg::funct3_to_size(req_q_i.funct3);

  // Data channel, always a single beat
  assign w_o.data = lane_data;
  assign w_o.strb = strb_base << byte_off;
  assign w_o.last = 1'b1;

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic              clock,
  input  logic              reset,

  // Stage handshakes
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output lsu_pkg::wb_res_t  res_o,

  // AXI4 master port
  output lsu_pkg::axi_aw_t  aw_o,
  output logic              aw_valid_o,
  input  logic              aw_ready_i,
  output lsu_pkg::axi_w_t   w_o,
  output logic              w_valid_o,
  input  logic              w_ready_i,
  input  lsu_pkg::axi_b_t   b_i,
  input  logic              b_valid_i,
  output logic              b_ready_o,
  output lsu_pkg::axi_ar_t  ar_o,
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  input  lsu_pkg::axi_r_t   r_i,
  input  logic              r_valid_i,
  output logic              r_ready_o
);

  lsu_pkg::lsu_req_t        req_q;
  logic                     acc_alu;
  logic                     r_done;
  logic                     b_done;
  logic [lsu_pkg::XLEN-1:0] load_data;

  lsu_fsm u_fsm (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .req_q_o     (req_q),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .w_valid_o   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_last_i    (r_i.last),
    .r_ready_o   (r_ready_o),
    .acc_alu_o   (acc_alu),
    .r_done_o    (r_done),
    .b_done_o    (b_done)
  );

  lsu_store_align #(
    .AXI_ID (AXI_ID)
  ) u_store_align (
    .req_q_i (req_q),
    .aw_o    (aw_o),
    .w_o     (w_o)
  );

  lsu_load_extract #(
    .AXI_ID (AXI_ID)
  ) u_load_extract (
    .req_q_i     (req_q),
    .ar_o        (ar_o),
    .r_data_i    (r_i.data),
    .load_data_o (load_data)
  );

  lsu_writeback u_writeback (
    .clock       (clock),
    .reset       (reset),
    .req_q_i     (req_q),
    .req_i       (req_i),
    .acc_alu_i   (acc_alu),
    .r_done_i    (r_done),
    .b_done_i    (b_done),
    .load_data_i (load_data),
    .r_resp_i    (r_i.resp),
    .b_resp_i    (b_i.resp),
    .res_o       (res_o)
  );

endmodule

/* hw/lsu_writeback.sv */
`timescale 1ns/1ps

module lsu_writeback (
  input  logic                     clock,
  input  logic                     reset,

  // Captured request and the live upstream request
  input  lsu_pkg::lsu_req_t        req_q_i,
  input  lsu_pkg::lsu_req_t        req_i,

  // Capture strobes from the FSM
  input  logic                     acc_alu_i,
  input  logic                     r_done_i,
  input  logic                     b_done_i,

  // Load data and bus responses
  input  logic [lsu_pkg::XLEN-1:0] load_data_i,
  input  logic [1:0]               r_resp_i,
  input  logic [1:0]               b_resp_i,

  output lsu_pkg::wb_res_t         res_o
);

  lsu_pkg::wb_res_t res_q;

  assign res_o = res_q;

  // --------------------------------------------------
  // Result register
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      res_q <= '0;
    end else if (acc_alu_i) begin
      // ALU value rides in the addr field
      res_q.rd    <= req_i.rd;
      res_q.data  <= req_i.addr;
      res_q.rd_we <= 1'b1;
      res_q.fault <= 1'b0;
    end else if (r_done_i) begin
      res_q.rd    <= req_q_i.rd;
      res_q.data  <= load_data_i;
      res_q.rd_we <= 1'b1;
      res_q.fault <= (r_resp_i != lsu_pkg::AXI_RESP_OKAY);
    end else if (b_done_i) begin
      // Stores write no register
      res_q.rd    <= req_q_i.rd;
      res_q.data  <= '0;
      res_q.rd_we <= 1'b0;
      res_q.fault <= (b_resp_i != lsu_pkg::AXI_RESP_OKAY);
    end
  end

endmodule

/* tb.f */
hw/lsu_pkg.sv
hw/lsu_fsm.sv
hw/lsu_store_align.sv
hw/lsu_load_extract.sv
hw/lsu_writeback.sv
hw/lsu_top.sv
test/tb_axi_mem.sv
test/tb_lsu_top.sv

/* test/tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem #(
  parameter logic [31:0] SEED = 32'h4a97_caaa
) (
  input  logic             clock,
  input  logic             reset,
  input  lsu_pkg::axi_aw_t aw_i,
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  lsu_pkg::axi_w_t  w_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  output lsu_pkg::axi_b_t  b_o,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  input  lsu_pkg::axi_ar_t ar_i,
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  output lsu_pkg::axi_r_t  r_o,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  // Last accepted payloads
  output lsu_pkg::axi_aw_t seen_aw_o,
  output lsu_pkg::axi_w_t  seen_w_o,
  output lsu_pkg::axi_ar_t seen_ar_o
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [31:0] mem [256];
  logic [31:0] lfsr_state;
  logic        ar_hs;
  logic        r_hs;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        rd_pend;
  logic        wr_pend;
  logic [1:0]  rd_delay;
  logic [1:0]  wr_delay;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Word contents depend on every bit of the word index
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'h5a, ~idx, idx + 8'h21, {idx[3:0], idx[7:4]}};
  endfunction

  initial begin
    lfsr_state = SEED;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    r_valid_o  = 1'b0;
    b_o        = '0;
    r_o        = '0;
    seen_aw_o  = '0;
    seen_w_o   = '0;
    seen_ar_o  = '0;
    rd_pend    = 1'b0;
    wr_pend    = 1'b0;
    rd_delay   = 2'd0;
    wr_delay   = 2'd0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(8'(i));
    end

    forever begin
      // Handshakes seen here complete on the next rising edge
      @(negedge clock);
      ar_hs = ar_valid_i && ar_ready_o;
      r_hs  = r_valid_o && r_ready_i;
      aw_hs = aw_valid_i && aw_ready_o;
      w_hs  = w_valid_i && w_ready_o;
      b_hs  = b_valid_o && b_ready_i;
      if (ar_hs) begin
        seen_ar_o = ar_i;
        rd_pend   = 1'b1;
        rd_delay  = 2'(take_bits(2));
      end
      if (aw_hs) begin
        seen_aw_o = aw_i;
      end
      if (w_hs) begin
        seen_w_o = w_i;
        // Error region keeps its contents
        if (!seen_aw_o.addr[12]) begin
          for (int lane = 0; lane < 4; lane++) begin
            if (w_i.strb[lane]) begin
              mem[seen_aw_o.addr[9:2]][8*lane +: 8] = w_i.data[8*lane +: 8];
            end
          end
        end
        wr_pend  = 1'b1;
        wr_delay = 2'(take_bits(2));
      end

      @(posedge clock);
      #1;
      if (!reset) begin
        rd_pend = 1'b0;
        wr_pend = 1'b0;
      end
      if (r_hs) begin
        r_valid_o = 1'b0;
      end
      if (b_hs) begin
        b_valid_o = 1'b0;
      end
      ar_ready_o = (take_bits(2) != 0);
      aw_ready_o = (take_bits(2) != 0);
      w_ready_o  = (take_bits(2) != 0);

      // Read response after a random delay
      if (rd_pend) begin
        if (rd_delay == 2'd0) begin
          r_o.id    = seen_ar_o.id;
          r_o.data  = mem[seen_ar_o.addr[9:2]];
          r_o.resp  = seen_ar_o.addr[12] ? RESP_SLVERR : lsu_pkg::AXI_RESP_OKAY;
          r_o.last  = 1'b1;
          r_valid_o = 1'b1;
          rd_pend   = 1'b0;
        end else begin
          rd_delay = rd_delay - 2'd1;
        end
      end

      // Write response after a random delay
      if (wr_pend) begin
        if (wr_delay == 2'd0) begin
          b_o.id    = seen_aw_o.id;
          b_o.resp  = seen_aw_o.addr[12] ? RESP_SLVERR : lsu_pkg::AXI_RESP_OKAY;
          b_valid_o = 1'b1;
          wr_pend   = 1'b0;
        end else begin
          wr_delay = wr_delay - 2'd1;
        end
      end
    end
  end

endmodule

/* test/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top;

  localparam logic [31:0] LFSR_SEED = 32'h4a97_caaa;
  localparam int          NUM_TESTS = 200;
  localparam int          TIMEOUT   = 100;
  // Non-zero so that a hard-wired ID shows up
  localparam logic [3:0]  BUS_ID    = 4'd9;

  logic              clock;
  logic              reset;
  logic              req_valid;
  logic              req_ready;
  lsu_pkg::lsu_req_t req;
  logic              res_valid;
  logic              res_ready;
  lsu_pkg::wb_res_t  res;

  lsu_pkg::axi_aw_t  aw;
  logic              aw_valid;
  logic              aw_ready;
  lsu_pkg::axi_w_t   w;
  logic              w_valid;
  logic              w_ready;
  lsu_pkg::axi_b_t   b;
  logic              b_valid;
  logic              b_ready;
  lsu_pkg::axi_ar_t  ar;
  logic              ar_valid;
  logic              ar_ready;
  lsu_pkg::axi_r_t   r;
  logic              r_valid;
  logic              r_ready;
  lsu_pkg::axi_aw_t  seen_aw;
  lsu_pkg::axi_w_t   seen_w;
  lsu_pkg::axi_ar_t  seen_ar;

  logic [31:0] lfsr_state;
  logic [31:0] ref_mem [256];
  int          err_count;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  lsu_top #(
    .AXI_ID (BUS_ID)
  ) u_dut (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_o       (res),
    .aw_o        (aw),
    .aw_valid_o  (aw_valid),
    .aw_ready_i  (aw_ready),
    .w_o         (w),
    .w_valid_o   (w_valid),
    .w_ready_i   (w_ready),
    .b_i         (b),
    .b_valid_i   (b_valid),
    .b_ready_o   (b_ready),
    .ar_o        (ar),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .r_i         (r),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready)
  );

  tb_axi_mem #(
    .SEED (LFSR_SEED)
  ) u_mem (
    .clock      (clock),
    .reset      (reset),
    .aw_i       (aw),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .seen_aw_o  (seen_aw),
    .seen_w_o   (seen_w),
    .seen_ar_o  (seen_ar)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_value(input logic [63:0] got_v, input logic [63:0] exp_v,
                             input string what);
    if (got_v !== exp_v) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got_v, exp_v);
      err_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // funct3[1:0] is log2 of the access size
  function automatic int access_bytes(input logic [2:0] f3);
    case (f3[1:0])
      2'd0:    return 1;
      2'd1:    return 2;
      default: return 4;
    endcase
  endfunction

  // Takes the loaded bytes already moved down to bit 0
  function automatic logic [31:0] extend_load(input logic [2:0] f3, input logic [31:0] v);
    case (f3)
      lsu_pkg::LB:  return 32'($signed(v[7:0]));
      lsu_pkg::LH:  return 32'($signed(v[15:0]));
      lsu_pkg::LBU: return 32'(v[7:0]);
      lsu_pkg::LHU: return 32'(v[15:0]);
      default:      return v;
    endcase
  endfunction

  function automatic string kind_name(input lsu_pkg::inst_kind_e k);
    case (k)
      lsu_pkg::KIND_ALU:  return "alu";
      lsu_pkg::KIND_LOAD: return "load";
      default:            return "store";
    endcase
  endfunction

  // --------------------------------------------------
  // Stimulus and reference model
  // --------------------------------------------------
  task automatic build_request(output lsu_pkg::lsu_req_t rq);
    logic [1:0] pick;
    logic       err;
    logic [3:0] word;
    logic [1:0] off;
    rq = '0;
    pick = 2'(take_bits(2));
    rq.rd = 5'(take_bits(5));
    rq.wdata = take_bits(32);
    if (pick == 2'd0) begin
      rq.kind   = lsu_pkg::KIND_ALU;
      rq.funct3 = 3'(take_bits(3));
      rq.addr   = take_bits(32);
    end else begin
      if (pick == 2'd3) begin
        rq.kind = lsu_pkg::KIND_STORE;
        case (take_bits(2) % 3)
          0:       rq.funct3 = lsu_pkg::SB;
          1:       rq.funct3 = lsu_pkg::SH;
          default: rq.funct3 = lsu_pkg::SW;
        endcase
      end else begin
        rq.kind = lsu_pkg::KIND_LOAD;
        case (take_bits(3) % 5)
          0:       rq.funct3 = lsu_pkg::LB;
          1:       rq.funct3 = lsu_pkg::LH;
          2:       rq.funct3 = lsu_pkg::LW;
          3:       rq.funct3 = lsu_pkg::LBU;
          default: rq.funct3 = lsu_pkg::LHU;
        endcase
      end
      // Few words so that loads often hit earlier stores
      err  = (take_bits(3) == 0);
      word = 4'(take_bits(4));
      off  = 2'(take_bits(2));
      if (access_bytes(rq.funct3) == 2) begin
        off[0] = 1'b0;
      end else if (access_bytes(rq.funct3) == 4) begin
        off = 2'd0;
      end
      rq.addr = {19'd0, err, 6'd0, word, off};
    end
  endtask

  task automatic apply_model(input lsu_pkg::lsu_req_t rq, output lsu_pkg::wb_res_t exp_res);
    logic [7:0] idx;
    int         off;
    int         nbytes;
    exp_res = '0;
    exp_res.rd = rq.rd;
    idx = rq.addr[9:2];
    off = int'(rq.addr[1:0]);
    nbytes = access_bytes(rq.funct3);
    case (rq.kind)
      lsu_pkg::KIND_ALU: begin
        exp_res.data  = rq.addr;
        exp_res.rd_we = 1'b1;
      end
      lsu_pkg::KIND_LOAD: begin
        exp_res.data  = extend_load(rq.funct3, ref_mem[idx] >> (8 * off));
        exp_res.rd_we = 1'b1;
        exp_res.fault = rq.addr[12];
      end
      default: begin
        exp_res.fault = rq.addr[12];
        // A faulting store leaves memory alone
        if (!rq.addr[12]) begin
          for (int k = 0; k < nbytes; k++) begin
            ref_mem[idx][8*(off+k) +: 8] = rq.wdata[8*k +: 8];
          end
        end
      end
    endcase
  endtask

  task automatic send_request(input lsu_pkg::lsu_req_t rq, output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    req = rq;
    req_valid = 1'b1;
    while (!ok && cycles < TIMEOUT) begin
      @(negedge clock);
      if (req_ready) begin
        ok = 1'b1;
      end
      next_cycle();
      cycles++;
    end
    req_valid = 1'b0;
    // Junk on the port shows that the request was latched
    req = {take_bits(32), take_bits(32), 10'(take_bits(10))};
    if (!ok) begin
      $display("Timeout: the DUT never accepted the request at %0t", $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic receive_result(input logic is_alu, output lsu_pkg::wb_res_t got,
                                output logic ok);
    int               cycles;
    logic             seen;
    lsu_pkg::wb_res_t first;
    ok = 1'b0;
    seen = 1'b0;
    cycles = 0;
    got = '0;
    first = '0;
    while (!ok && cycles < TIMEOUT) begin
      res_ready = (take_bits(2) != 0);
      @(negedge clock);
      check_value(64'(req_ready), 64'd0, "req_ready while an instruction is in flight");
      if (is_alu && cycles == 0) begin
        check_value(64'(res_valid), 64'd1, "ALU res_valid one cycle after accept");
      end
      if (res_valid) begin
        if (!seen) begin
          first = res;
          seen = 1'b1;
        end else begin
          check_value(64'(res), 64'(first), "res held under back-pressure");
        end
        if (res_ready) begin
          got = res;
          ok = 1'b1;
        end
      end
      next_cycle();
      cycles++;
    end
    res_ready = 1'b0;
    if (!ok) begin
      $display("Timeout: the result handshake never completed at %0t", $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_bus_payload(input lsu_pkg::lsu_req_t rq);
    int          nbytes;
    int          off;
    logic [2:0]  size;
    logic [3:0]  strb;
    logic [31:0] mask;
    logic [31:0] lanes;
    nbytes = access_bytes(rq.funct3);
    off = int'(rq.addr[1:0]);
    size = (nbytes == 1) ? 3'd0 : (nbytes == 2) ? 3'd1 : 3'd2;
    if (rq.kind == lsu_pkg::KIND_LOAD) begin
      check_value(64'(seen_ar.addr), 64'(rq.addr), "AR address");
      check_value(64'(seen_ar.size), 64'(size), "AR size");
      check_value(64'(seen_ar.id), 64'(BUS_ID), "AR id");
    end else if (rq.kind == lsu_pkg::KIND_STORE) begin
      strb = '0;
      mask = '0;
      for (int k = 0; k < nbytes; k++) begin
        strb[off+k] = 1'b1;
        mask[8*(off+k) +: 8] = 8'hff;
      end
      lanes = rq.wdata << (8 * off);
      check_value(64'(seen_aw.addr), 64'(rq.addr), "AW address");
      check_value(64'(seen_aw.size), 64'(size), "AW size");
      check_value(64'(seen_aw.id), 64'(BUS_ID), "AW id");
      check_value(64'(seen_w.strb), 64'(strb), "W strobe");
      check_value(64'(seen_w.data & mask), 64'(lanes & mask), "W lane data");
      check_value(64'(seen_w.last), 64'd1, "W last");
    end
  endtask

  task automatic run_one(input int t);
    lsu_pkg::lsu_req_t rq;
    lsu_pkg::wb_res_t  exp_res;
    lsu_pkg::wb_res_t  got_res;
    int                errs_before;
    logic              ok;
    errs_before = err_count;
    got_res = '0;
    build_request(rq);
    apply_model(rq, exp_res);
    send_request(rq, ok);
    if (ok) begin
      receive_result(rq.kind == lsu_pkg::KIND_ALU, got_res, ok);
    end
    if (ok) begin
      check_value(64'(got_res), 64'(exp_res), "writeback result");
      check_bus_payload(rq);
    end
    tests_run++;
    if (!ok || err_count != errs_before) begin
      tests_failed++;
    end
    $display("test %0d %s funct3=%0d addr=%h: %s", t, kind_name(rq.kind), rq.funct3,
             rq.addr, (ok && err_count == errs_before) ? "pass" : "fail");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int errs_before;
    reset = 1'b0;
    req_valid = 1'b0;
    req = '0;
    res_ready = 1'b0;
    lfsr_state = LFSR_SEED;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;

    repeat (4) @(posedge clock);
    #1;
    reset = 1'b1;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = u_mem.mem[i];
    end

    // Idle outputs right after reset
    errs_before = err_count;
    @(negedge clock);
    check_value(64'(req_ready), 64'd1, "req_ready after reset");
    check_value(64'(res_valid), 64'd0, "res_valid after reset");
    check_value(64'(aw_valid), 64'd0, "aw_valid after reset");
    check_value(64'(w_valid), 64'd0, "w_valid after reset");
    check_value(64'(b_ready), 64'd0, "b_ready after reset");
    check_value(64'(ar_valid), 64'd0, "ar_valid after reset");
    check_value(64'(r_ready), 64'd0, "r_ready after reset");
    next_cycle();
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
    end
    $display("test 0 reset state: %s", (err_count == errs_before) ? "pass" : "fail");

    for (int t = 1; t <= NUM_TESTS && !timed_out; t++) begin
      run_one(t);
    end

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             err_count);
    if (err_count == 0 && tests_failed == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
